/* dma_stimulus.txt */
// columns: op, register address, data, expected value, one 16-bit hex word each
// op 1 write, 2 read, 3 program channel, 4 check channel, 5 transfer, 6 no grant, 0 end
// channel ops: address column is the channel, data the address, expected the count
// transfer: address column is the expected dack, data is type<<8 | dreq
0002 0008 0000 0000
0003 0000 1000 0010
0003 0001 2000 0020
0003 0002 3000 0030
0003 0003 4000 0005
0004 0000 1000 0010
0004 0001 2000 0020
0004 0002 3000 0030
0004 0003 4000 0005
0001 000B 0004 0000
0001 000B 0009 0000
0001 000B 0026 0000
0001 000B 002B 0000
0001 000A 0000 0000
0001 000A 0001 0000
0001 000A 0002 0000
0001 000A 0003 0000
0005 0002 0206 2000
0005 0004 010C 3000
0005 0001 010F 1000
0005 0008 0208 4000
0004 0000 1001 000F
0004 0001 2001 001F
0004 0002 2FFF 002F
0004 0003 3FFF 0004
0001 0008 0010 0000
0005 0001 010F 1001
0005 0002 020F 2001
0005 0004 010F 2FFF
0005 0008 020F 3FFF
0003 0003 5000 0001
0005 0008 0208 5000
0005 0008 0208 4FFF
0006 0000 0008 0000
0004 0003 4FFE FFFF
0002 0008 0000 0008
0002 0008 0000 0000
0000 0000 0000 0000

/* sim.f */
+incdir+.
dmaRegPkg.sv
dmaXferPkg.sv
dmaRegFile.sv
dmaPriority.sv
dmaTiming.sv
dmaTop.sv
dmaTiming_asserts.sv
tbDma.sv

/* run.sh */
#!/bin/sh
# build and run the DMA testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbDma -f sim.f -o tbDma
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tbDma 2>&1)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
	exit 0
fi
exit 1

/* tbDma.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dma_defs.svh"

module tbDma;
	// at most 40 records, none of which needs anywhere near 100 cycles
	localparam int MAX_RECORDS = 40;
	localparam int CYCLE_LIMIT = MAX_RECORDS * 100;
	// window in which a masked request must stay unanswered
	localparam int NOGRANT_CYCLES = 10;

	logic busIf;
	logic arstN;
	logic csN;
	logic cpuIorN;
	logic cpuIowN;
	logic [3:0] regAddr;
	logic [`DMA_DATA_W-1:0] dbIn;
	logic [`DMA_DATA_W-1:0] dbOut;
	logic dbOe;
	logic [`DMA_CHANNELS-1:0] dreq;
	logic [`DMA_CHANNELS-1:0] dack;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	logic iorN;
	logic iowN;
	logic memrN;
	logic memwN;
	logic [`DMA_DATA_W-1:0] addrOut;

	// four words per record: op, address, data, expected
	logic [15:0] stim [4*MAX_RECORDS];
	int errCount = 0;
	int testCount = 0;
	int cycleCount = 0;

	dmaTop DUT (.*);

	initial
	begin
		busIf = 1'b0;
		forever
			#50 busIf = ~busIf;
	end

	// hard stop if a handshake never completes
	always @(posedge busIf)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycleCount);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic reportMismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		errCount++;
		$display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
	endtask

	// all tasks start and end 5 ns after a rising edge
	task automatic cpuWrite(input logic [3:0] addr, input logic [7:0] data);
		csN = 1'b0;
		cpuIowN = 1'b0;
		regAddr = addr;
		dbIn = data;
		@(posedge busIf);
		#5;
		csN = 1'b1;
		cpuIowN = 1'b1;
	endtask

	// one-cycle read, sampled mid-cycle while the bus is stable
	task automatic cpuRead(input logic [3:0] addr, output logic [7:0] data);
		csN = 1'b0;
		cpuIorN = 1'b0;
		regAddr = addr;
		@(negedge busIf);
		data = dbOut;
		if (dbOe !== 1'b1)
			reportMismatch("dbOe", dbOe, 1'b1);
		@(posedge busIf);
		#5;
		csN = 1'b1;
		cpuIorN = 1'b1;
	endtask

	// low byte first after clearing the byte pointer
	task automatic progChannel(input logic [1:0] chan, input logic [15:0] addrVal,
		input logic [15:0] cntVal);
		cpuWrite(`DMA_REG_CLRFF, 8'h00);
		cpuWrite({1'b0, chan, 1'b0}, addrVal[7:0]);
		cpuWrite({1'b0, chan, 1'b0}, addrVal[15:8]);
		cpuWrite({1'b0, chan, 1'b1}, cntVal[7:0]);
		cpuWrite({1'b0, chan, 1'b1}, cntVal[15:8]);
	endtask

	task automatic checkChannel(input logic [1:0] chan, input logic [15:0] expAddr,
		input logic [15:0] expCnt);
		logic [7:0] lo;
		logic [7:0] hi;
		cpuWrite(`DMA_REG_CLRFF, 8'h00);
		cpuRead({1'b0, chan, 1'b0}, lo);
		cpuRead({1'b0, chan, 1'b0}, hi);
		if ({hi, lo} !== expAddr)
			reportMismatch("current address", {hi, lo}, expAddr);
		cpuRead({1'b0, chan, 1'b1}, lo);
		cpuRead({1'b0, chan, 1'b1}, hi);
		if ({hi, lo} !== expCnt)
			reportMismatch("current count", {hi, lo}, expCnt);
	endtask

	// single transfer through the hrq/hlda and dreq/dack handshakes
	task automatic runTransfer(input logic [3:0] pattern, input logic [3:0] expDack,
		input logic [1:0] xferType, input logic [15:0] expAddr);
		logic wrType;
		wrType = (xferType == 2'b01);
		dreq = pattern;
		do
		begin
			@(posedge busIf);
			#5;
		end
		while (!hrq);
		hlda = 1'b1;
		do
		begin
			@(posedge busIf);
			#5;
		end
		while (!adstb);
		// S1, upper byte on the data bus
		if (dbOe !== 1'b1)
			reportMismatch("dbOe", dbOe, 1'b1);
		if ({dbOut, addrOut} !== expAddr)
			reportMismatch("transfer address", {dbOut, addrOut}, expAddr);
		// S2 and S4
		repeat (2)
		begin
			@(posedge busIf);
			#5;
			if (dack !== expDack)
				reportMismatch("dack", dack, expDack);
			if (aen !== 1'b1)
				reportMismatch("aen", aen, 1'b1);
			if (iorN !== !wrType)
				reportMismatch("iorN", iorN, !wrType);
			if (memwN !== !wrType)
				reportMismatch("memwN", memwN, !wrType);
			if (memrN !== wrType)
				reportMismatch("memrN", memrN, wrType);
			if (iowN !== wrType)
				reportMismatch("iowN", iowN, wrType);
			// requester lets go once dack is seen
			dreq = '0;
		end
		@(posedge busIf);
		#5;
		if (hrq !== 1'b0)
			reportMismatch("hrq", hrq, 1'b0);
		hlda = 1'b0;
	endtask

	task automatic checkNoGrant(input logic [3:0] pattern);
		dreq = pattern;
		repeat (NOGRANT_CYCLES)
		begin
			@(posedge busIf);
			#5;
			if (hrq !== 1'b0)
				reportMismatch("hrq", hrq, 1'b0);
		end
		dreq = '0;
	endtask

	initial
	begin
		logic [15:0] op;
		logic [15:0] addrF;
		logic [15:0] dataF;
		logic [15:0] expF;
		logic [7:0] rdByte;
		int errBefore;
		arstN = 1'b0;
		csN = 1'b1;
		cpuIorN = 1'b1;
		cpuIowN = 1'b1;
		regAddr = '0;
		dbIn = '0;
		dreq = '0;
		hlda = 1'b0;
		for (int i = 0; i < 4*MAX_RECORDS; i++)
			stim[i] = '0;
		$readmemh("dma_stimulus.txt", stim);
		repeat (2) @(posedge busIf);
		#5;
		arstN = 1'b1;

		// idle bus after reset
		if (hrq !== 1'b0)
			reportMismatch("hrq", hrq, 1'b0);
		if (aen !== 1'b0)
			reportMismatch("aen", aen, 1'b0);
		if (adstb !== 1'b0)
			reportMismatch("adstb", adstb, 1'b0);
		if (dack !== '0)
			reportMismatch("dack", dack, '0);
		if ({iorN, iowN, memrN, memwN} !== 4'hf)
			reportMismatch("strobes", {iorN, iowN, memrN, memwN}, 4'hf);
		testCount++;
		$display("test 0 reset outputs: %s", (errCount == 0) ? "ok" : "failed");

		for (int rec = 0; rec < MAX_RECORDS; rec++)
		begin
			op = stim[4*rec];
			addrF = stim[4*rec+1];
			dataF = stim[4*rec+2];
			expF = stim[4*rec+3];
			if (op == 16'h0)
				break;
			errBefore = errCount;
			case (op)
				16'h1: cpuWrite(addrF[3:0], dataF[7:0]);
				16'h2:
				begin
					cpuRead(addrF[3:0], rdByte);
					if (rdByte !== expF[7:0])
						reportMismatch("dbOut", rdByte, expF[7:0]);
				end
				16'h3: progChannel(addrF[1:0], dataF, expF);
				16'h4: checkChannel(addrF[1:0], dataF, expF);
				16'h5: runTransfer(dataF[3:0], addrF[3:0], dataF[9:8], expF);
				16'h6: checkNoGrant(dataF[3:0]);
				default:
				begin
					errCount++;
					$display("record %0d has unknown operation %h", rec, op);
				end
			endcase
			testCount++;
			$display("test %0d op %0h: %s", rec + 1, op,
				(errCount == errBefore) ? "ok" : "failed");
		end

		$display("%0d tests run, %0d errors", testCount, errCount);
		if (errCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* dmaTiming_asserts.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dma_defs.svh"

module dmaTimingAsserts (
	input logic busIf,
	input logic arstN,
	input logic aen,
	input logic adstb,
	input logic [`DMA_CHANNELS-1:0] dack,
	input logic iorN,
	input logic iowN
);

	// address strobe only in S1
	assert property (@(posedge busIf) disable iff (!arstN) adstb |=> !adstb)
		else $error("adstb held longer than one cycle");

	// aen covers S1, S2 and S4, then drops
	assert property (@(posedge busIf) disable iff (!arstN)
		$rose(aen) |-> aen ##1 aen ##1 aen ##1 !aen)
		else $error("aen not high for exactly three cycles");

	// one channel served at a time, and only in S2 and S4
	assert property (@(posedge busIf) disable iff (!arstN)
		(dack != '0) |-> $onehot(dack) && aen && !adstb)
		else $error("dack not one-hot or outside S2 and S4");

	// I/O strobes exclusive and only under dack
	assert property (@(posedge busIf) disable iff (!arstN)
		(!iorN || !iowN) |-> (iorN || iowN) && (dack != '0))
		else $error("iorN and iowN low together or without dack");

endmodule

bind dmaTiming dmaTimingAsserts uTimingAsserts (
	.busIf(busIf), .arstN(arstN), .aen(aen), .adstb(adstb),
	.dack(dack), .iorN(iorN), .iowN(iowN)
);

`default_nettype wire

/* dmaTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dma_defs.svh"

module dmaTop (
	input logic busIf,
	input logic arstN,
	input logic csN,
	input logic cpuIorN,
	input logic cpuIowN,
	input logic [3:0] regAddr,
	input logic [`DMA_DATA_W-1:0] dbIn,
	output logic [`DMA_DATA_W-1:0] dbOut,
	output logic dbOe,
	input logic [`DMA_CHANNELS-1:0] dreq,
	output logic [`DMA_CHANNELS-1:0] dack,
	input logic hlda,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic iorN,
	output logic iowN,
	output logic memrN,
	output logic memwN,
	output logic [`DMA_DATA_W-1:0] addrOut
);
	import dmaRegPkg::*;
	import dmaXferPkg::*;

	logic [`DMA_DATA_W-1:0] regDbOut;
	logic [`DMA_CHANNELS-1:0] mask;
	commandReg_t cmd;
	logic [`DMA_ADDR_W-1:0] curAddr;
	xferType_t curType;
	logic reqValid;
	chan_t winChan;
	logic xferDone;
	chan_t servChan;
	logic [`DMA_DATA_W-1:0] addrHigh;
	logic addrHighOe;

	dmaRegFile uRegFile (
		.busIf, .arstN, .csN, .cpuIorN, .cpuIowN, .regAddr, .dbIn, .hlda,
		.xferDone, .servChan, .dbOut(regDbOut), .mask, .cmd, .curAddr, .curType
	);

	dmaPriority uPriority (
		.busIf, .arstN, .dreq, .mask, .cmd, .xferDone, .servChan, .reqValid, .winChan
	);

	dmaTiming uTiming (
		.busIf, .arstN, .reqValid, .winChan, .hlda, .curAddr, .curType,
		.hrq, .aen, .adstb, .dack, .iorN, .iowN, .memrN, .memwN,
		.addrOut, .addrHigh, .addrHighOe, .xferDone, .servChan
	);

	// S1 owns the data bus for the upper address byte
	assign dbOut = addrHighOe ? addrHigh : regDbOut;
	assign dbOe = (~csN & ~cpuIorN & ~hlda) | addrHighOe;

endmodule

`default_nettype wire

/* dmaTiming.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dma_defs.svh"

module dmaTiming (
	input logic busIf,
	input logic arstN,
	input logic reqValid,
	input dmaXferPkg::chan_t winChan,
	input logic hlda,
	input logic [`DMA_ADDR_W-1:0] curAddr,
	input dmaXferPkg::xferType_t curType,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic [`DMA_CHANNELS-1:0] dack,
	output logic iorN,
	output logic iowN,
	output logic memrN,
	output logic memwN,
	output logic [`DMA_DATA_W-1:0] addrOut,
	output logic [`DMA_DATA_W-1:0] addrHigh,
	output logic addrHighOe,
	output logic xferDone,
	output dmaXferPkg::chan_t servChan
);
	import dmaXferPkg::*;

	xferState_t state;
	xferState_t nextState;
	logic strobeOn;

	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= SI;
			servChan <= '0;
		end
		else
		begin
			state <= nextState;
			// winner is frozen for the whole cycle
			if (state == SI && reqValid)
				servChan <= winChan;
		end
	end

	// S0 waits on hlda, then three fixed states
	always_comb
	begin
		unique case (state)
			SI: nextState = reqValid ? S0 : SI;
			S0: nextState = hlda ? S1 : S0;
			S1: nextState = S2;
			S2: nextState = S4;
			S4: nextState = SI;
			default: nextState = SI;
		endcase
	end

	assign hrq = (state != SI);
	assign aen = (state == S1) || (state == S2) || (state == S4);
	// upper byte goes out on the data bus for the external latch
	assign adstb = (state == S1);
	assign addrHighOe = (state == S1);
	assign addrHigh = curAddr[`DMA_ADDR_W-1 -: `DMA_DATA_W];
	assign addrOut = aen ? curAddr[`DMA_DATA_W-1:0] : '0;

	// strobes and dack in S2 and S4
	assign strobeOn = (state == S2) || (state == S4);
	assign dack = strobeOn ? (`DMA_CHANNELS'(1) << servChan) : '0;
	// write: device to memory
	assign iorN = ~(strobeOn && curType == XFER_WRITE);
	assign memwN = ~(strobeOn && curType == XFER_WRITE);
	// read: memory to device
	assign memrN = ~(strobeOn && curType == XFER_READ);
	assign iowN = ~(strobeOn && curType == XFER_READ);

	assign xferDone = (state == S4);

endmodule

`default_nettype wire

/* dmaPriority.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dma_defs.svh"

module dmaPriority (
	input logic busIf,
	input logic arstN,
	input logic [`DMA_CHANNELS-1:0] dreq,
	input logic [`DMA_CHANNELS-1:0] mask,
	input dmaRegPkg::commandReg_t cmd,
	input logic xferDone,
	input dmaXferPkg::chan_t servChan,
	output logic reqValid,
	output dmaXferPkg::chan_t winChan
);
	import dmaXferPkg::*;

	logic [`DMA_CHANNELS-1:0] qualReq;
	logic [2*`DMA_CHANNELS-1:0] prioOrder;

	// masked or disabled requests never reach the arbiter
	assign qualReq = dreq & ~mask & {`DMA_CHANNELS{~cmd.ctrlDisable}};

	// scan from the last slot down so slot 0 is written last and wins
	always_comb
	begin
		chan_t slotChan;
		reqValid = 1'b0;
		winChan = '0;
		for (int k = `DMA_CHANNELS-1; k >= 0; k--)
		begin
			slotChan = chan_t'(prioOrder[2*k +: 2]);
			if (qualReq[slotChan])
			begin
				reqValid = 1'b1;
				winChan = slotChan;
			end
		end
	end

	// fixed mode pins the order, rotating puts the served channel last
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
			prioOrder <= `DMA_PRIO_RESET;
		else if (!cmd.rotPrio)
			prioOrder <= `DMA_PRIO_RESET;
		else if (xferDone)
			for (int k = 0; k < `DMA_CHANNELS; k++)
				prioOrder[2*k +: 2] <= servChan + chan_t'(k + 1);
	end

endmodule

`default_nettype wire

/* dmaRegFile.sv */
`timescale 1ns/10ps
`default_nettype none
`include "dma_defs.svh"

module dmaRegFile (
	input logic busIf,
	input logic arstN,
	input logic csN,
	input logic cpuIorN,
	input logic cpuIowN,
	input logic [3:0] regAddr,
	input logic [`DMA_DATA_W-1:0] dbIn,
	input logic hlda,
	input logic xferDone,
	input dmaXferPkg::chan_t servChan,
	output logic [`DMA_DATA_W-1:0] dbOut,
	output logic [`DMA_CHANNELS-1:0] mask,
	output dmaRegPkg::commandReg_t cmd,
	output logic [`DMA_ADDR_W-1:0] curAddr,
	output dmaXferPkg::xferType_t curType
);
	import dmaRegPkg::*;
	import dmaXferPkg::*;

	logic cpuWr;
	logic cpuRd;
	logic chanSel;
	chan_t regChan;
	logic ffPtr;
	logic tcHit;
	ctrlWord_u ctrlWr;
	logic [`DMA_ADDR_W-1:0] curAddrR [`DMA_CHANNELS];
	logic [`DMA_ADDR_W-1:0] curCnt [`DMA_CHANNELS];
	modeWord_t modeR [`DMA_CHANNELS];
	logic [`DMA_CHANNELS-1:0] tcBits;
	logic [`DMA_ADDR_W-1:0] rdWord;

	// CPU access is locked out while the bus is held
	assign cpuWr = ~csN & ~cpuIowN & ~hlda;
	assign cpuRd = ~csN & ~cpuIorN & ~hlda;
	// addresses 0..7 are channel address/count pairs
	assign chanSel = ~regAddr[3];
	assign regChan = chan_t'(regAddr[2:1]);
	assign ctrlWr = dbIn;
	// count wraps from 0 on this transfer
	assign tcHit = xferDone && (curCnt[servChan] == '0);

	// byte pointer, low byte first
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
			ffPtr <= 1'b0;
		else if (cpuWr && regAddr == `DMA_REG_CLRFF)
			ffPtr <= 1'b0;
		else if ((cpuWr || cpuRd) && chanSel)
			ffPtr <= ~ffPtr;
	end

	// current address and count registers
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < `DMA_CHANNELS; i++)
			begin
				curAddrR[i] <= '0;
				curCnt[i] <= '0;
			end
		end
		else if (cpuWr && chanSel)
		begin
			// odd address is the word count
			if (regAddr[0] && ffPtr)
			begin
				curCnt[regChan][`DMA_ADDR_W-1 -: `DMA_DATA_W] <= dbIn;
			end
			else if (regAddr[0])
			begin
				curCnt[regChan][`DMA_DATA_W-1:0] <= dbIn;
			end
			else if (ffPtr)
			begin
				curAddrR[regChan][`DMA_ADDR_W-1 -: `DMA_DATA_W] <= dbIn;
			end
			else
			begin
				curAddrR[regChan][`DMA_DATA_W-1:0] <= dbIn;
			end
		end
		else if (xferDone)
		begin
			// step address per mode, count always goes down
			if (modeR[servChan].addrDec)
				curAddrR[servChan] <= curAddrR[servChan] - 1'b1;
			else
				curAddrR[servChan] <= curAddrR[servChan] + 1'b1;
			curCnt[servChan] <= curCnt[servChan] - 1'b1;
		end
	end

	// command, mode, mask and terminal count
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
		begin
			cmd <= '0;
			mask <= '1;
			tcBits <= '0;
			for (int i = 0; i < `DMA_CHANNELS; i++)
				modeR[i] <= '0;
		end
		else
		begin
			if (cpuWr && regAddr == `DMA_REG_CMD)
				cmd <= dbIn;
			if (cpuWr && regAddr == `DMA_REG_MODE)
				modeR[ctrlWr.mode.chan] <= ctrlWr.mode;
			if (cpuWr && regAddr == `DMA_REG_MASK)
				mask[ctrlWr.mask.chan] <= ctrlWr.mask.maskBit;
			// status read clears tc
			if (cpuRd && regAddr == `DMA_REG_CMD)
				tcBits <= '0;
			// TC masks the channel until the CPU unmasks it
			if (tcHit)
			begin
				tcBits[servChan] <= 1'b1;
				mask[servChan] <= 1'b1;
			end
		end
	end

	// readback, byte picked by the pointer
	assign rdWord = regAddr[0] ? curCnt[regChan] : curAddrR[regChan];

	always_comb
	begin
		dbOut = '0;
		if (chanSel)
			dbOut = ffPtr ? rdWord[`DMA_ADDR_W-1 -: `DMA_DATA_W] : rdWord[`DMA_DATA_W-1:0];
		else if (regAddr == `DMA_REG_CMD)
			// no software requests, so the request nibble reads zero
			dbOut = {{(`DMA_DATA_W-`DMA_CHANNELS){1'b0}}, tcBits};
	end

	// transfer side sees the serviced channel only
	assign curAddr = curAddrR[servChan];
	assign curType = xferType_t'(modeR[servChan].xferType);

endmodule

`default_nettype wire

/* dmaXferPkg.sv */
`default_nettype none

package dmaXferPkg;

	// one-hot transfer states, S3 is never entered
	typedef enum logic [5:0] {
		SI = 6'b000001,
		S0 = 6'b000010,
		S1 = 6'b000100,
		S2 = 6'b001000,
		S4 = 6'b100000
	} xferState_t;

	// direction as seen from memory
	typedef enum logic [1:0] {
		XFER_WRITE = 2'b01,
		XFER_READ = 2'b10
	} xferType_t;

	typedef logic [1:0] chan_t;

endpackage

`default_nettype wire

/* dmaRegPkg.sv */
`default_nettype none

package dmaRegPkg;

	// command byte, only disable and rotating priority have an effect
	typedef struct packed {
		logic [2:0] rsvdHi;
		logic rotPrio;
		logic rsvdMid;
		logic ctrlDisable;
		logic [1:0] rsvdLo;
	} commandReg_t;

	// mode byte as written by the CPU
	typedef struct packed {
		logic [1:0] mode;
		logic addrDec;
		logic autoInit;
		logic [1:0] xferType;
		logic [1:0] chan;
	} modeWord_t;

	// single-mask byte
	typedef struct packed {
		logic [4:0] rsvd;
		logic maskBit;
		logic [1:0] chan;
	} maskWord_t;

	// the written byte reads as either word, picked by register address
	typedef union packed {
		modeWord_t mode;
		maskWord_t mask;
	} ctrlWord_u;

endpackage

`default_nettype wire

/* dma_defs.svh */
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// controller size
`define DMA_CHANNELS 4
// address and word count registers are 16 bits, the data bus one byte
`define DMA_ADDR_W 16
`define DMA_DATA_W 8

// CPU register map, the low 8 addresses hold the channel registers
`define DMA_REG_CMD 4'd8
`define DMA_REG_MASK 4'd10
`define DMA_REG_MODE 4'd11
`define DMA_REG_CLRFF 4'd12

// two bits per slot, slot 0 in the low bits is served first
`define DMA_PRIO_RESET 8'b11_10_01_00

`endif
